// ==== common/i3c_target_pkg.sv ====
// I3C standby target types shared by bus monitor, target FSM and TTI flow

package i3c_target_pkg;

  // Data byte on the bus and in the TTI queues
  typedef logic [7:0] byte_t;

  // 7-bit I3C/I2C address
  typedef logic [6:0] addr_t;

  // I3C broadcast address
  localparam addr_t BroadcastAddr = 7'h7E;

  // Bus events from the monitor, all pulses are one cycle wide
  typedef struct packed {
    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    // Synchronized SDA level, aligned with the SCL edge pulses
    logic sda;
  } bus_evt_t;

  // Direction of the current private transfer
  typedef enum logic [1:0] {
    XFER_NONE,
    XFER_WRITE,
    XFER_READ
  } xfer_e;

  // Address compare results
  typedef struct packed {
    logic sta;
    logic dyn;
    logic bcast;
  } addr_hit_t;

endpackage

// ==== rtl/bus_monitor.sv ====
// Bus monitor that synchronizes SCL/SDA and reports START, STOP and SCL edges
`timescale 1ns/1ps

module bus_monitor
  import i3c_target_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     scl_i,
  input  logic     sda_i,
  output bus_evt_t evt_o
);

  logic     scl_s1_q;
  logic     scl_s2_q;
  logic     scl_d_q;
  logic     sda_s1_q;
  logic     sda_s2_q;
  logic     sda_d_q;
  logic     scl_high;
  bus_evt_t evt_d;
  bus_evt_t evt_q;

  // Two-flop synchronizers plus one delayed copy for edge detection
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_s1_q <= 1'b1;
      scl_s2_q <= 1'b1;
      scl_d_q  <= 1'b1;
      sda_s1_q <= 1'b1;
      sda_s2_q <= 1'b1;
      sda_d_q  <= 1'b1;
    end else begin
      scl_s1_q <= scl_i;
      scl_s2_q <= scl_s1_q;
      scl_d_q  <= scl_s2_q;
      sda_s1_q <= sda_i;
      sda_s2_q <= sda_s1_q;
      sda_d_q  <= sda_s2_q;
    end
  end

  // SCL stable high across the SDA change
  assign scl_high = scl_s2_q && scl_d_q;

  always_comb begin
    evt_d.start    = scl_high && sda_d_q && !sda_s2_q;
    evt_d.stop     = scl_high && !sda_d_q && sda_s2_q;
    evt_d.scl_rise = scl_s2_q && !scl_d_q;
    evt_d.scl_fall = !scl_s2_q && scl_d_q;
    evt_d.sda      = sda_s2_q;
  end

  // Edge register adds the third clock of latency
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      evt_q <= bus_evt_t'{start: 1'b0, stop: 1'b0, scl_rise: 1'b0, scl_fall: 1'b0, sda: 1'b1};
    end else begin
      evt_q <= evt_d;
    end
  end

  assign evt_o = evt_q;

  // SDA never moves on the clock where SCL moves
  a_sda_stable_at_scl_edge: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (scl_s2_q != scl_d_q) |-> (sda_s2_q == sda_d_q)
  );

endmodule

// ==== rtl/addr_match.sv ====
// Address match: compares a received address with static, dynamic and broadcast
`timescale 1ns/1ps

module addr_match
  import i3c_target_pkg::*;
#(
  parameter addr_t StaticAddr   = 7'h22,
  parameter addr_t DynAddr      = 7'h5A,
  parameter bit    DynAddrValid = 1'b1
) (
  input  addr_t     addr_i,
  output addr_hit_t hit_o
);

  logic sta_eq;
  logic dyn_eq;
  logic bcast_eq;

  assign sta_eq   = (addr_i == StaticAddr);
  assign dyn_eq   = (addr_i == DynAddr);
  assign bcast_eq = (addr_i == BroadcastAddr);

  always_comb begin
    hit_o.sta   = sta_eq;
    // No dynamic address assigned yet
    hit_o.dyn   = DynAddrValid && dyn_eq;
    hit_o.bcast = bcast_eq;
  end

endmodule

// ==== target/target_fsm.sv ====
// SDR target FSM: address phase, ACK, private writes with T-bit parity and private reads
`timescale 1ns/1ps

module target_fsm
  import i3c_target_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  bus_evt_t  evt_i,
  output addr_t     addr_o,
  input  addr_hit_t hit_i,
  output logic      sda_o,
  output logic      rx_valid_o,
  output byte_t     rx_data_o,
  input  logic      rx_ready_i,
  input  logic      tx_valid_i,
  input  byte_t     tx_data_i,
  output logic      tx_ready_o,
  output xfer_e     xfer_o,
  output logic      addr_valid_o,
  output logic      parity_err_o,
  output logic      rx_overflow_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_ADDR_ACK,
    ST_WDATA,
    ST_WTBIT,
    ST_RDATA,
    ST_RTBIT,
    ST_IGNORE
  } state_e;

  state_e     state_q;
  logic [2:0] bit_cnt_q;
  logic       ack_slot_q;
  logic       more_q;
  logic       sda_q;
  logic       addr_valid_q;
  logic       rx_valid_q;
  logic       parity_err_q;
  xfer_e      xfer_q;
  byte_t      sreg_q;
  byte_t      rx_data_q;
  addr_t      addr_q;
  logic       rnw_q;

  logic shift_in;
  logic shift_out;
  logic addr_done;
  logic t_rise;
  logic parity_ok;
  logic ack_wr;
  logic ack_rd;

  assign shift_in  = evt_i.scl_rise && (state_q == ST_ADDR || state_q == ST_WDATA);
  assign addr_done = shift_in && (state_q == ST_ADDR) && (bit_cnt_q == 3'd7);
  assign shift_out = evt_i.scl_fall && (state_q == ST_RDATA) && (bit_cnt_q != 3'd7);
  assign t_rise    = evt_i.scl_rise && (state_q == ST_WTBIT);

  // Odd parity over data byte and T bit
  assign parity_ok = ^{sreg_q, evt_i.sda};

  assign ack_wr = !rnw_q && (hit_i.sta || hit_i.dyn || hit_i.bcast);
  // Broadcast read is not a valid private read
  assign ack_rd = rnw_q && (hit_i.sta || hit_i.dyn) && tx_valid_i;

  // Take a byte at the end of the ACK slot or after a T bit of 1
  assign tx_ready_o = evt_i.scl_fall &&
      ((state_q == ST_ADDR_ACK && ack_slot_q && xfer_q == XFER_READ) ||
       (state_q == ST_RTBIT && more_q));

  always_ff @(posedge clk_i) begin
    if (shift_in) begin
      sreg_q <= {sreg_q[6:0], evt_i.sda};
    end else if (tx_ready_o) begin
      sreg_q <= tx_data_i;
    end else if (shift_out) begin
      sreg_q <= {sreg_q[6:0], 1'b0};
    end
    if (addr_done) begin
      addr_q <= sreg_q[6:0];
      rnw_q  <= evt_i.sda;
    end
    if (t_rise) begin
      rx_data_q <= sreg_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      bit_cnt_q    <= '0;
      ack_slot_q   <= 1'b0;
      more_q       <= 1'b0;
      sda_q        <= 1'b1;
      addr_valid_q <= 1'b0;
      rx_valid_q   <= 1'b0;
      parity_err_q <= 1'b0;
      xfer_q       <= XFER_NONE;
    end else begin
      rx_valid_q   <= 1'b0;
      parity_err_q <= 1'b0;
      if (evt_i.stop) begin
        state_q      <= ST_IDLE;
        sda_q        <= 1'b1;
        addr_valid_q <= 1'b0;
        xfer_q       <= XFER_NONE;
      end else if (evt_i.start) begin
        // START and repeated START both restart the address phase
        state_q      <= ST_ADDR;
        bit_cnt_q    <= '0;
        sda_q        <= 1'b1;
        addr_valid_q <= 1'b0;
        xfer_q       <= XFER_NONE;
      end else begin
        unique case (state_q)
          ST_ADDR: begin
            if (evt_i.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                state_q    <= ST_ADDR_ACK;
                ack_slot_q <= 1'b0;
              end
            end
          end
          ST_ADDR_ACK: begin
            if (evt_i.scl_fall && !ack_slot_q) begin
              ack_slot_q <= 1'b1;
              if (ack_wr) begin
                sda_q        <= 1'b0;
                addr_valid_q <= 1'b1;
                // Bytes after 7E are not forwarded
                xfer_q       <= (hit_i.sta || hit_i.dyn) ? XFER_WRITE : XFER_NONE;
              end else if (ack_rd) begin
                sda_q        <= 1'b0;
                addr_valid_q <= 1'b1;
                xfer_q       <= XFER_READ;
              end
            end else if (evt_i.scl_fall) begin
              bit_cnt_q <= '0;
              unique case (xfer_q)
                XFER_WRITE: begin
                  sda_q   <= 1'b1;
                  state_q <= ST_WDATA;
                end
                XFER_READ: begin
                  sda_q   <= tx_data_i[7];
                  state_q <= ST_RDATA;
                end
                default: begin
                  sda_q   <= 1'b1;
                  state_q <= ST_IGNORE;
                end
              endcase
            end
          end
          ST_WDATA: begin
            if (evt_i.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                state_q <= ST_WTBIT;
              end
            end
          end
          ST_WTBIT: begin
            if (evt_i.scl_rise) begin
              state_q      <= ST_WDATA;
              rx_valid_q   <= parity_ok;
              parity_err_q <= !parity_ok;
            end
          end
          ST_RDATA: begin
            if (evt_i.scl_fall && bit_cnt_q == 3'd7) begin
              // T bit low ends the read
              sda_q   <= tx_valid_i;
              more_q  <= tx_valid_i;
              state_q <= ST_RTBIT;
            end else if (evt_i.scl_fall) begin
              sda_q     <= sreg_q[6];
              bit_cnt_q <= bit_cnt_q + 3'd1;
            end
          end
          ST_RTBIT: begin
            if (evt_i.scl_fall && more_q) begin
              sda_q     <= tx_data_i[7];
              bit_cnt_q <= '0;
              state_q   <= ST_RDATA;
            end else if (evt_i.scl_fall) begin
              sda_q   <= 1'b1;
              state_q <= ST_IGNORE;
            end
          end
          default: begin
            // Idle and ignore wait for START or STOP
            sda_q <= 1'b1;
          end
        endcase
      end
    end
  end

  assign addr_o        = addr_q;
  assign sda_o         = sda_q;
  assign rx_valid_o    = rx_valid_q;
  assign rx_data_o     = rx_data_q;
  assign xfer_o        = xfer_q;
  assign addr_valid_o  = addr_valid_q;
  assign parity_err_o  = parity_err_q;
  // Bus cannot be stalled, so a refused byte is lost
  assign rx_overflow_o = rx_valid_q && !rx_ready_i;

  a_idle_sda_released: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (state_q == ST_IDLE) |-> sda_o
  );

  a_rx_valid_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rx_valid_o |=> !rx_valid_o
  );

endmodule

// ==== rtl/tti_flow.sv ====
// TTI flow: one-entry RX buffer and TX prefetch between target FSM and TTI queues
`timescale 1ns/1ps

module tti_flow
  import i3c_target_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  xfer_e xfer_i,
  input  logic  stop_i,
  input  logic  rx_valid_i,
  input  byte_t rx_data_i,
  output logic  rx_ready_o,
  output logic  tx_valid_o,
  output byte_t tx_data_o,
  input  logic  tx_ready_i,
  output logic  rx_queue_wvalid_o,
  input  logic  rx_queue_wready_i,
  output byte_t rx_queue_wdata_o,
  output logic  rx_queue_wflush_o,
  input  logic  tx_queue_rvalid_i,
  output logic  tx_queue_rready_o,
  input  byte_t tx_queue_rdata_i
);

  logic  rx_full_q;
  byte_t rx_buf_q;
  logic  tx_full_q;
  byte_t tx_buf_q;
  logic  rx_take;
  logic  rx_drain;
  logic  tx_load;
  logic  tx_take;

  assign rx_ready_o = !rx_full_q;
  assign rx_take    = rx_valid_i && rx_ready_o;
  assign rx_drain   = rx_full_q && rx_queue_wready_i;

  // No prefetch while a write owns the bus
  assign tx_queue_rready_o = !tx_full_q && (xfer_i != XFER_WRITE);
  assign tx_load           = tx_queue_rvalid_i && tx_queue_rready_o;
  assign tx_take           = tx_full_q && tx_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_full_q <= 1'b0;
      tx_full_q <= 1'b0;
    end else begin
      if (rx_take) begin
        rx_full_q <= 1'b1;
      end else if (rx_drain) begin
        rx_full_q <= 1'b0;
      end
      if (tx_load) begin
        tx_full_q <= 1'b1;
      end else if (tx_take) begin
        tx_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_take) begin
      rx_buf_q <= rx_data_i;
    end
    if (tx_load) begin
      tx_buf_q <= tx_queue_rdata_i;
    end
  end

  assign rx_queue_wvalid_o = rx_full_q;
  assign rx_queue_wdata_o  = rx_buf_q;
  // End of a private write
  assign rx_queue_wflush_o = stop_i && (xfer_i == XFER_WRITE);

  assign tx_valid_o = tx_full_q;
  assign tx_data_o  = tx_buf_q;

  a_wdata_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rx_queue_wvalid_o && !rx_queue_wready_i |=> rx_queue_wvalid_o && $stable(rx_queue_wdata_o)
  );

endmodule

// ==== rtl/controller_standby_i3c.sv ====
// I3C standby controller: SDR target with address match and TTI queue flow
`timescale 1ns/1ps

module controller_standby_i3c
  import i3c_target_pkg::*;
#(
  parameter addr_t StaticAddr   = 7'h22,
  parameter addr_t DynAddr      = 7'h5A,
  parameter bit    DynAddrValid = 1'b1
) (
  input  logic       clk_i,
  input  logic       rst_n_i,

  // SCL/SDA, SDA output is open drain
  input  logic       ctrl_scl_i,
  input  logic       ctrl_sda_i,
  output logic       ctrl_sda_o,

  // TTI RX data queue
  output logic       rx_queue_wvalid_o,
  input  logic       rx_queue_wready_i,
  output byte_t      rx_queue_wdata_o,
  output logic       rx_queue_wflush_o,

  // TTI TX data queue
  input  logic       tx_queue_rvalid_i,
  output logic       tx_queue_rready_o,
  input  byte_t      tx_queue_rdata_i,

  output logic       bus_start_o,
  output logic       bus_stop_o,
  // Address with RnW in bit 0
  output logic [7:0] bus_addr_o,
  output logic       bus_addr_valid_o,
  output logic       parity_err_o,
  output logic       rx_overflow_o
);

  bus_evt_t  bus_evt;
  addr_t     fsm_addr;
  addr_hit_t addr_hit;
  xfer_e     xfer;
  logic      rx_byte_valid;
  byte_t     rx_byte;
  logic      rx_byte_ready;
  logic      tx_byte_valid;
  byte_t     tx_byte;
  logic      tx_byte_ready;

  bus_monitor i_bus_monitor (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .scl_i   (ctrl_scl_i),
    .sda_i   (ctrl_sda_i),
    .evt_o   (bus_evt)
  );

  addr_match #(
    .StaticAddr   (StaticAddr),
    .DynAddr      (DynAddr),
    .DynAddrValid (DynAddrValid)
  ) i_addr_match (
    .addr_i (fsm_addr),
    .hit_o  (addr_hit)
  );

  target_fsm i_target_fsm (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .evt_i         (bus_evt),
    .addr_o        (fsm_addr),
    .hit_i         (addr_hit),
    .sda_o         (ctrl_sda_o),
    .rx_valid_o    (rx_byte_valid),
    .rx_data_o     (rx_byte),
    .rx_ready_i    (rx_byte_ready),
    .tx_valid_i    (tx_byte_valid),
    .tx_data_i     (tx_byte),
    .tx_ready_o    (tx_byte_ready),
    .xfer_o        (xfer),
    .addr_valid_o  (bus_addr_valid_o),
    .parity_err_o  (parity_err_o),
    .rx_overflow_o (rx_overflow_o)
  );

  tti_flow i_tti_flow (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .xfer_i            (xfer),
    .stop_i            (bus_evt.stop),
    .rx_valid_i        (rx_byte_valid),
    .rx_data_i         (rx_byte),
    .rx_ready_o        (rx_byte_ready),
    .tx_valid_o        (tx_byte_valid),
    .tx_data_o         (tx_byte),
    .tx_ready_i        (tx_byte_ready),
    .rx_queue_wvalid_o (rx_queue_wvalid_o),
    .rx_queue_wready_i (rx_queue_wready_i),
    .rx_queue_wdata_o  (rx_queue_wdata_o),
    .rx_queue_wflush_o (rx_queue_wflush_o),
    .tx_queue_rvalid_i (tx_queue_rvalid_i),
    .tx_queue_rready_o (tx_queue_rready_o),
    .tx_queue_rdata_i  (tx_queue_rdata_i)
  );

  assign bus_start_o = bus_evt.start;
  assign bus_stop_o  = bus_evt.stop;

  // RnW follows the acknowledged transfer direction while the address is valid
  assign bus_addr_o = {fsm_addr, xfer == XFER_READ};

endmodule

// ==== testbench/tb_controller_standby_i3c.sv ====
// Testbench for the I3C standby controller with a bus controller model and TTI queue models
`timescale 1ns/1ps

module tb_controller_standby_i3c
  import i3c_target_pkg::*;
();

  localparam int HalfBit   = 8;
  localparam int WaitLimit = 4000;
  localparam int ReadLen   = 4;

  logic       clk;
  logic       rst_n;
  logic       scl_drv;
  logic       sda_drv;
  logic       sda_out;
  logic       sda_bus;
  logic       rx_wvalid;
  logic       rx_wready;
  byte_t      rx_wdata;
  logic       rx_wflush;
  logic       tx_rvalid;
  logic       tx_rready;
  byte_t      tx_rdata;
  logic       bus_start;
  logic       bus_stop;
  logic [7:0] bus_addr;
  logic       bus_addr_valid;
  logic       parity_err;
  logic       rx_overflow;

  // Observed DUT activity
  byte_t      rx_got[$];
  int         start_cnt = 0;
  int         stop_cnt = 0;
  int         flush_cnt = 0;
  int         perr_cnt = 0;
  int         ovf_cnt = 0;
  logic [7:0] addr_seen = 8'h00;

  // TX queue model filled by the tests and drained by the queue process
  byte_t      tx_mem [0:15];
  int         tx_wr = 0;
  int         tx_rd = 0;

  byte_t      rx_exp[$];
  int         seed;
  int         mismatch_cnt;
  int         fail_cnt;

  // Open-drain SDA
  assign sda_bus = sda_drv & sda_out;

  controller_standby_i3c #(
    .StaticAddr   (7'h22),
    .DynAddr      (7'h5A),
    .DynAddrValid (1'b1)
  ) i_controller_standby_i3c (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .ctrl_scl_i        (scl_drv),
    .ctrl_sda_i        (sda_bus),
    .ctrl_sda_o        (sda_out),
    .rx_queue_wvalid_o (rx_wvalid),
    .rx_queue_wready_i (rx_wready),
    .rx_queue_wdata_o  (rx_wdata),
    .rx_queue_wflush_o (rx_wflush),
    .tx_queue_rvalid_i (tx_rvalid),
    .tx_queue_rready_o (tx_rready),
    .tx_queue_rdata_i  (tx_rdata),
    .bus_start_o       (bus_start),
    .bus_stop_o        (bus_stop),
    .bus_addr_o        (bus_addr),
    .bus_addr_valid_o  (bus_addr_valid),
    .parity_err_o      (parity_err),
    .rx_overflow_o     (rx_overflow)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Sampled before the DUT flops update on this edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (rx_wvalid && rx_wready) begin
        rx_got.push_back(rx_wdata);
      end
      if (rx_wflush) flush_cnt++;
      if (bus_start) start_cnt++;
      if (bus_stop) stop_cnt++;
      if (parity_err) perr_cnt++;
      if (rx_overflow) ovf_cnt++;
      if (bus_addr_valid) addr_seen = bus_addr;
    end
  end

  // TX queue serves tx_mem in order
  initial begin
    logic take;
    tx_rvalid = 1'b0;
    tx_rdata  = 8'h00;
    forever begin
      @(posedge clk);
      take = tx_rvalid && tx_rready;
      @(negedge clk);
      if (take) tx_rd++;
      tx_rvalid = (tx_rd < tx_wr);
      tx_rdata  = tx_rvalid ? tx_mem[tx_rd[3:0]] : 8'h00;
    end
  end

  task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: expected 0x%02h, got 0x%02h", name, exp, got);
      mismatch_cnt++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, exp, got);
      mismatch_cnt++;
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, exp, got);
      mismatch_cnt++;
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    assert (cond) else begin
      $display("ERROR: %s", msg);
      fail_cnt++;
    end
  endtask

  task automatic next_payload(output byte_t b);
    int r;
    r = $random(seed);
    b = r[7:0];
  endtask

  // One SCL period with SDA set while SCL is low and sampled just before the rise
  task automatic drive_bit(input logic b, output logic sampled);
    repeat (2) @(negedge clk);
    sda_drv = b;
    repeat (HalfBit - 2) @(negedge clk);
    sampled = sda_bus;
    scl_drv = 1'b1;
    repeat (HalfBit) @(negedge clk);
    scl_drv = 1'b0;
  endtask

  task automatic send_start();
    repeat (HalfBit) @(negedge clk);
    sda_drv = 1'b0;
    repeat (HalfBit) @(negedge clk);
    scl_drv = 1'b0;
  endtask

  task automatic send_stop();
    repeat (2) @(negedge clk);
    sda_drv = 1'b0;
    repeat (HalfBit - 2) @(negedge clk);
    scl_drv = 1'b1;
    repeat (HalfBit) @(negedge clk);
    sda_drv = 1'b1;
    repeat (HalfBit) @(negedge clk);
  endtask

  task automatic send_address(input addr_t addr, input logic rnw, output logic ack_level);
    logic s;
    int   i;
    for (i = 6; i >= 0; i--) begin
      drive_bit(addr[i], s);
    end
    drive_bit(rnw, s);
    // SDA released in the ACK slot so the target can pull it low
    drive_bit(1'b1, ack_level);
  endtask

  task automatic write_byte_t(input byte_t data, input logic bad_t);
    logic s;
    logic t_bit;
    int   i;
    for (i = 7; i >= 0; i--) begin
      drive_bit(data[i], s);
    end
    // Odd parity over data and T
    t_bit = (~^data) ^ bad_t;
    drive_bit(t_bit, s);
  endtask

  task automatic read_byte_t(output byte_t data, output logic t_bit);
    logic s;
    int   i;
    for (i = 7; i >= 0; i--) begin
      drive_bit(1'b1, s);
      data[i] = s;
    end
    drive_bit(1'b1, t_bit);
  endtask

  task automatic send_private_write(input addr_t addr, input int count, input int bad_idx);
    logic  level;
    byte_t data;
    int    i;
    send_start();
    send_address(addr, 1'b0, level);
    compare_bit("ctrl_sda_o in ACK slot", level, 1'b0);
    compare_bit("bus_addr_valid_o", bus_addr_valid, 1'b1);
    compare_byte("bus_addr_o", addr_seen, {addr, 1'b0});
    for (i = 0; i < count; i++) begin
      next_payload(data);
      write_byte_t(data, i == bad_idx);
      if (i != bad_idx) rx_exp.push_back(data);
    end
    send_stop();
  endtask

  task automatic wait_rx_writes(input int n);
    int cycles;
    cycles = 0;
    while (rx_got.size() < n && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    expect_true(rx_got.size() >= n, "timeout waiting for RX queue writes");
  endtask

  task automatic wait_rx_drained();
    int cycles;
    cycles = 0;
    while (rx_wvalid && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    expect_true(!rx_wvalid, "timeout waiting for the RX buffer to drain");
  endtask

  task automatic wait_tx_taken(input int n);
    int cycles;
    cycles = 0;
    while (tx_rd < n && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    expect_true(tx_rd >= n, "timeout waiting for the TX queue prefetch");
  endtask

  task automatic check_rx_written(input int base);
    int i;
    compare_count("RX queue writes", rx_got.size() - base, rx_exp.size());
    for (i = 0; i < rx_exp.size() && base + i < rx_got.size(); i++) begin
      compare_byte("rx_queue_wdata_o", rx_got[base + i], rx_exp[i]);
    end
  endtask

  task automatic check_reset_values();
    compare_bit("ctrl_sda_o", sda_out, 1'b1);
    compare_bit("rx_queue_wvalid_o", rx_wvalid, 1'b0);
    compare_bit("rx_queue_wflush_o", rx_wflush, 1'b0);
    compare_bit("bus_start_o", bus_start, 1'b0);
    compare_bit("bus_stop_o", bus_stop, 1'b0);
    compare_bit("bus_addr_valid_o", bus_addr_valid, 1'b0);
    compare_bit("parity_err_o", parity_err, 1'b0);
    compare_bit("rx_overflow_o", rx_overflow, 1'b0);
  endtask

  task automatic test_write_matching();
    int base;
    int flush0;
    int start0;
    int stop0;
    base   = rx_got.size();
    flush0 = flush_cnt;
    start0 = start_cnt;
    stop0  = stop_cnt;
    rx_exp.delete();
    send_private_write(7'h22, 3, -1);
    send_private_write(7'h5A, 3, -1);
    wait_rx_writes(base + 6);
    check_rx_written(base);
    compare_count("rx_queue_wflush_o pulses", flush_cnt - flush0, 2);
    compare_count("bus_start_o pulses", start_cnt - start0, 2);
    compare_count("bus_stop_o pulses", stop_cnt - stop0, 2);
  endtask

  task automatic test_no_match();
    logic  level;
    byte_t data;
    int    base;
    base = rx_got.size();
    send_start();
    send_address(7'h33, 1'b0, level);
    compare_bit("ctrl_sda_o in ACK slot", level, 1'b1);
    next_payload(data);
    write_byte_t(data, 1'b0);
    send_stop();
    compare_count("RX queue writes", rx_got.size() - base, 0);
  endtask

  task automatic test_bad_parity();
    int base;
    int perr0;
    base  = rx_got.size();
    perr0 = perr_cnt;
    rx_exp.delete();
    send_private_write(7'h22, 3, 1);
    wait_rx_writes(base + 2);
    check_rx_written(base);
    compare_count("parity_err_o pulses", perr_cnt - perr0, 1);
  endtask

  task automatic test_private_read();
    byte_t exp_data [ReadLen];
    byte_t got;
    logic  t_bit;
    logic  level;
    int    rd0;
    int    i;
    rd0 = tx_rd;
    for (i = 0; i < ReadLen; i++) begin
      next_payload(exp_data[i]);
      tx_mem[tx_wr[3:0]] = exp_data[i];
      tx_wr++;
    end
    wait_tx_taken(rd0 + 1);
    send_start();
    send_address(7'h22, 1'b1, level);
    compare_bit("ctrl_sda_o in ACK slot", level, 1'b0);
    compare_byte("bus_addr_o", addr_seen, {7'h22, 1'b1});
    for (i = 0; i < ReadLen; i++) begin
      read_byte_t(got, t_bit);
      compare_byte("ctrl_sda_o read byte", got, exp_data[i]);
      compare_bit("ctrl_sda_o T bit", t_bit, i < ReadLen - 1);
    end
    send_stop();
    compare_count("TX queue reads", tx_rd - rd0, ReadLen);
  endtask

  task automatic test_empty_read_and_broadcast();
    logic  level;
    byte_t data;
    int    base;
    int    flush0;
    expect_true(tx_rd == tx_wr, "TX queue model still holds bytes before the empty read");
    send_start();
    send_address(7'h22, 1'b1, level);
    compare_bit("ctrl_sda_o in ACK slot", level, 1'b1);
    send_stop();
    base   = rx_got.size();
    flush0 = flush_cnt;
    send_start();
    send_address(BroadcastAddr, 1'b0, level);
    compare_bit("ctrl_sda_o in ACK slot", level, 1'b0);
    next_payload(data);
    write_byte_t(data, 1'b0);
    send_stop();
    compare_count("RX queue writes", rx_got.size() - base, 0);
    compare_count("rx_queue_wflush_o pulses", flush_cnt - flush0, 0);
  endtask

  task automatic test_rx_full();
    int base;
    int ovf0;
    base = rx_got.size();
    ovf0 = ovf_cnt;
    rx_exp.delete();
    rx_wready = 1'b0;
    send_private_write(7'h5A, 3, -1);
    compare_count("rx_overflow_o pulses", ovf_cnt - ovf0, 2);
    // The full buffer keeps offering the first byte
    compare_bit("rx_queue_wvalid_o", rx_wvalid, 1'b1);
    compare_byte("rx_queue_wdata_o", rx_wdata, rx_exp[0]);
    // Only the byte held in the one-entry buffer survives
    while (rx_exp.size() > 1) begin
      void'(rx_exp.pop_back());
    end
    rx_wready = 1'b1;
    wait_rx_writes(base + 1);
    wait_rx_drained();
    check_rx_written(base);
  endtask

  initial begin
    seed         = 32'h807c_6d4c;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    rst_n        = 1'b0;
    scl_drv      = 1'b1;
    sda_drv      = 1'b1;
    rx_wready    = 1'b1;
    repeat (3) @(negedge clk);
    check_reset_values();
    rst_n = 1'b1;
    repeat (4) @(negedge clk);

    test_write_matching();
    test_no_match();
    test_bad_parity();
    test_private_read();
    test_empty_read_and_broadcast();
    test_rx_full();

    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== i3c_standby.f ====
common/i3c_target_pkg.sv
rtl/bus_monitor.sv
rtl/addr_match.sv
target/target_fsm.sv
rtl/tti_flow.sv
rtl/controller_standby_i3c.sv
testbench/tb_controller_standby_i3c.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the I3C standby controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_controller_standby_i3c \
  -f i3c_standby.f \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qF 'All tests passed!' sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi
